// File: csr_pkg.sv
package csr_pkg;

  //////////////////////////////////////////////////////////////////////
  // csr addresses
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRET      = 12'hB02,
    CSR_MINSTRETH     = 12'hB82
  } csr_num_e;

  // csr instruction flavour
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // same address word, either an exact register or a counter group + index
  typedef union packed {
    csr_num_e num;
    struct packed {
      logic [6:0] group;  // addr[11:5]
      logic [4:0] idx;    // counter index 0..31
    } cnt;
  } csr_addr_u;

  // upper seven address bits of the counter groups
  localparam logic [6:0] CSR_GRP_MCOUNTER  = 7'h58;  // 0xB00..0xB1F
  localparam logic [6:0] CSR_GRP_MCOUNTERH = 7'h5C;  // 0xB80..0xB9F
  localparam logic [6:0] CSR_GRP_MHPMEVENT = 7'h19;  // 0x320..0x33F

  //////////////////////////////////////////////////////////////////////
  // field positions
  //////////////////////////////////////////////////////////////////////

  // mie / mip
  localparam int unsigned CSR_MSIX_BIT = 3;
  localparam int unsigned CSR_MTIX_BIT = 7;
  localparam int unsigned CSR_MEIX_BIT = 11;

  // mstatus
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;  // mpp is two bits wide

  // rv32 ic, mxl = 1 in bits 31:30
  localparam logic [31:0] MISA_VALUE = 32'h4000_0104;

  // stored cause: irq flag on top of a 5-bit code
  localparam int unsigned MCAUSE_W = 6;

  // mhpmcounter3 is the first event counter
  localparam int unsigned HPM_FIRST_IDX = 3;

endpackage

// File: csr_bus_if.sv
`timescale 1ns/1ps

interface csr_bus_if import csr_pkg::*; ();

  // access, from the op unit
  csr_addr_u   addr;
  logic [31:0] wdata;   // already merged with read data for set/clear
  logic        we;      // one cycle per qualified write

  // answer, from the register block
  logic [31:0] rdata;
  logic        hit;     // addr names a register of this block

  modport master (
    output addr, wdata, we,
    input  rdata, hit
  );

  modport slave (
    input  addr, wdata, we,
    output rdata, hit
  );

endinterface

// File: csr_op_unit.sv
`timescale 1ns/1ps

module csr_op_unit import csr_pkg::*; (
  input  logic        csr_access_i,
  input  logic [11:0] csr_addr_i,
  input  logic [31:0] csr_wdata_i,
  input  csr_op_e     csr_op_i,
  input  logic        instr_new_i,
  output logic [31:0] csr_rdata_o,
  output logic        illegal_csr_o,
  csr_bus_if.master   trap_bus,
  csr_bus_if.master   cnt_bus
);

  logic [31:0] wdata_int;   // value to commit
  logic        wreq;        // op modifies the csr
  logic        any_hit;
  logic        ro_write;    // write into 0xC00..0xFFF

  //////////////////////////////////////////////////////////////////////
  // read merge
  //////////////////////////////////////////////////////////////////////

  // blocks decode disjoint addresses, at most one hit
  assign csr_rdata_o = ({32{trap_bus.hit}} & trap_bus.rdata) |
                       ({32{cnt_bus.hit}}  & cnt_bus.rdata);

  assign any_hit = trap_bus.hit | cnt_bus.hit;

  //////////////////////////////////////////////////////////////////////
  // write data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wreq = 1'b1;
    case (csr_op_i)
      CSR_OP_WRITE: wdata_int = csr_wdata_i;
      CSR_OP_SET:   wdata_int = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: wdata_int = ~csr_wdata_i & csr_rdata_o;
      default: begin  // read
        wdata_int = csr_wdata_i;
        wreq      = 1'b0;
      end
    endcase
  end

  // top two address bits set means read-only space
  assign ro_write = wreq && (csr_addr_i[11:10] == 2'b11);

  assign illegal_csr_o = csr_access_i & (~any_hit | ro_write);

  // same access goes to both blocks
  assign trap_bus.addr  = csr_addr_i;
  assign trap_bus.wdata = wdata_int;
  assign cnt_bus.addr   = csr_addr_i;
  assign cnt_bus.wdata  = wdata_int;

  // one-cycle enable, dropped on illegal access
  assign trap_bus.we = csr_access_i & instr_new_i & wreq & ~illegal_csr_o;
  assign cnt_bus.we  = csr_access_i & instr_new_i & wreq & ~illegal_csr_o;

endmodule

// File: csr_trap_regs.sv
`timescale 1ns/1ps

module csr_trap_regs import csr_pkg::*; #(
  parameter logic [31:0] MtvecResetAddr = 32'h0000_0000
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                irq_software_i,
  input  logic                irq_timer_i,
  input  logic                irq_external_i,
  input  logic                csr_save_cause_i,
  input  logic                csr_save_if_i,
  input  logic [31:0]         pc_if_i,
  input  logic [31:0]         pc_id_i,
  input  logic [MCAUSE_W-1:0] csr_mcause_i,
  input  logic [31:0]         csr_mtval_i,
  input  logic                csr_mret_i,
  csr_bus_if.slave            bus,
  output logic                irq_pending_o,
  output logic                mstatus_mie_o,
  output logic [31:0]         mepc_o,
  output logic [31:0]         mtvec_o
);

  // mstatus, mpp is hardwired to machine mode
  logic                mstatus_mie_q, mstatus_mie_d;
  logic                mstatus_mpie_q, mstatus_mpie_d;
  logic [2:0]          mie_q, mie_d;         // {external, timer, software}
  logic [31:0]         mscratch_q, mscratch_d;
  logic [31:0]         mepc_q, mepc_d;
  logic [MCAUSE_W-1:0] mcause_q, mcause_d;
  logic [31:0]         mtval_q, mtval_d;
  logic [31:8]         mtvec_q, mtvec_d;     // low byte fixed to 0x01
  logic [2:0]          mip;

  // pending = raw line masked by enable, no state
  assign mip = {irq_external_i, irq_timer_i, irq_software_i} & mie_q;

  //////////////////////////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    bus.rdata = '0;
    bus.hit   = 1'b1;
    case (bus.addr.num)
      CSR_MSTATUS: begin
        bus.rdata[MSTATUS_MPP_LSB +: 2] = 2'b11;
        bus.rdata[MSTATUS_MPIE_BIT]     = mstatus_mpie_q;
        bus.rdata[MSTATUS_MIE_BIT]      = mstatus_mie_q;
      end
      CSR_MISA: bus.rdata = MISA_VALUE;
      CSR_MIE: begin
        bus.rdata[CSR_MSIX_BIT] = mie_q[0];
        bus.rdata[CSR_MTIX_BIT] = mie_q[1];
        bus.rdata[CSR_MEIX_BIT] = mie_q[2];
      end
      CSR_MIP: begin
        bus.rdata[CSR_MSIX_BIT] = mip[0];
        bus.rdata[CSR_MTIX_BIT] = mip[1];
        bus.rdata[CSR_MEIX_BIT] = mip[2];
      end
      CSR_MSCRATCH: bus.rdata = mscratch_q;
      CSR_MEPC:     bus.rdata = mepc_q;
      CSR_MCAUSE: begin
        // irq flag back to bit 31
        bus.rdata = {mcause_q[MCAUSE_W-1], {(32 - MCAUSE_W){1'b0}},
                     mcause_q[MCAUSE_W-2:0]};
      end
      CSR_MTVAL: bus.rdata = mtval_q;
      CSR_MTVEC: bus.rdata = mtvec_o;
      default:   bus.hit   = 1'b0;  // not ours
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // next state: sw write, then trap save / mret on top
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_mie_d  = mstatus_mie_q;
    mstatus_mpie_d = mstatus_mpie_q;
    mie_d          = mie_q;
    mscratch_d     = mscratch_q;
    mepc_d         = mepc_q;
    mcause_d       = mcause_q;
    mtval_d        = mtval_q;
    mtvec_d        = mtvec_q;

    if (bus.we) begin
      case (bus.addr.num)
        CSR_MSTATUS: begin
          mstatus_mie_d  = bus.wdata[MSTATUS_MIE_BIT];
          mstatus_mpie_d = bus.wdata[MSTATUS_MPIE_BIT];
        end
        CSR_MIE: begin
          mie_d = {bus.wdata[CSR_MEIX_BIT], bus.wdata[CSR_MTIX_BIT],
                   bus.wdata[CSR_MSIX_BIT]};
        end
        CSR_MSCRATCH: mscratch_d = bus.wdata;
        CSR_MEPC:     mepc_d     = {bus.wdata[31:1], 1'b0};  // halfword aligned
        CSR_MCAUSE:   mcause_d   = {bus.wdata[31], bus.wdata[MCAUSE_W-2:0]};
        CSR_MTVAL:    mtval_d    = bus.wdata;
        CSR_MTVEC:    mtvec_d    = bus.wdata[31:8];  // 256-byte aligned base
        default: ;
      endcase
    end

    // trap entry beats a same-cycle sw write
    if (csr_save_cause_i) begin
      mepc_d         = csr_save_if_i ? pc_if_i : pc_id_i;
      mcause_d       = csr_mcause_i;
      mtval_d        = csr_mtval_i;
      mstatus_mpie_d = mstatus_mie_q;
      mstatus_mie_d  = 1'b0;  // irqs off in handler
    end else if (csr_mret_i) begin
      mstatus_mie_d  = mstatus_mpie_q;
      mstatus_mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mtval_q        <= '0;
      mtvec_q        <= MtvecResetAddr[31:8];
    end else begin
      mstatus_mie_q  <= mstatus_mie_d;
      mstatus_mpie_q <= mstatus_mpie_d;
      mie_q          <= mie_d;
      mscratch_q     <= mscratch_d;
      mepc_q         <= mepc_d;
      mcause_q       <= mcause_d;
      mtval_q        <= mtval_d;
      mtvec_q        <= mtvec_d;
    end
  end

  assign irq_pending_o = |mip;
  assign mstatus_mie_o = mstatus_mie_q;
  assign mepc_o        = mepc_q;
  assign mtvec_o       = {mtvec_q, 8'h01};  // vectored mode

endmodule

// File: csr_perf_counters.sv
`timescale 1ns/1ps

module csr_perf_counters import csr_pkg::*; #(
  parameter int unsigned HpmCounterNum   = 4,
  parameter int unsigned HpmCounterWidth = 40
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     instr_ret_i,
  input  logic     mem_load_i,
  input  logic     mem_store_i,
  input  logic     branch_i,
  input  logic     branch_taken_i,
  csr_bus_if.slave bus
);

  // slot 0 mcycle, slot 1 minstret, slots 2.. mhpmcounter3..
  localparam int unsigned NumCnt = 2 + HpmCounterNum;
  localparam logic [63:0] HpmMask = 64'((65'd1 << HpmCounterWidth) - 65'd1);
  // absent event counters read as inhibited
  localparam logic [31:0] InhibitForce = {32{1'b1}} << (HPM_FIRST_IDX + HpmCounterNum);

  logic [31:0]       mcountinhibit_q, mcountinhibit_d;
  logic [31:0]       inhibit_eff;
  logic              inhibit_we;
  logic [3:0]        hpm_event;
  logic              lo_sel, hi_sel;    // counter group match
  logic [NumCnt-1:0] cnt_incr, cnt_lo_we, cnt_hi_we;
  logic [63:0]       cnt_mask [NumCnt];
  logic [63:0]       cnt_q [NumCnt];
  logic [63:0]       cnt_d [NumCnt];

  // csr index of a counter slot
  function automatic int unsigned slot_idx(input int unsigned s);
    return (s == 0) ? 0 : s + 1;
  endfunction

  assign hpm_event   = {branch_taken_i, branch_i, mem_store_i, mem_load_i};
  assign inhibit_eff = mcountinhibit_q | InhibitForce;
  assign inhibit_we  = bus.we && (bus.addr.num == CSR_MCOUNTINHIBIT);
  assign lo_sel      = (bus.addr.cnt.group == CSR_GRP_MCOUNTER);
  assign hi_sel      = (bus.addr.cnt.group == CSR_GRP_MCOUNTERH);

  //////////////////////////////////////////////////////////////////////
  // read and hit
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    bus.rdata = '0;
    bus.hit   = 1'b0;
    if (bus.addr.num == CSR_MCOUNTINHIBIT) begin
      bus.hit   = 1'b1;
      bus.rdata = inhibit_eff;
    end else if (bus.addr.cnt.group == CSR_GRP_MHPMEVENT) begin
      bus.hit = (bus.addr.cnt.idx >= HPM_FIRST_IDX);  // selectors read zero
    end else if (lo_sel || hi_sel) begin
      // fixed counters by exact address, event counters by index
      bus.hit = (bus.addr.cnt.idx >= HPM_FIRST_IDX) ||
                (bus.addr.num inside {CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH});
      for (int unsigned s = 0; s < NumCnt; s++) begin
        if (bus.addr.cnt.idx == slot_idx(s)) begin
          bus.rdata = hi_sel ? cnt_q[s][63:32] : cnt_q[s][31:0];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // counter update
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mcountinhibit_d    = inhibit_we ? bus.wdata : mcountinhibit_q;
    mcountinhibit_d[1] = 1'b0;  // no mtime here

    for (int unsigned s = 0; s < NumCnt; s++) begin
      cnt_mask[s]  = (s < 2) ? {64{1'b1}} : HpmMask;
      cnt_incr[s]  = (s == 0) ? 1'b1 : (s == 1) ? instr_ret_i : hpm_event[s-2];
      cnt_lo_we[s] = bus.we && lo_sel && (bus.addr.cnt.idx == slot_idx(s));
      cnt_hi_we[s] = bus.we && hi_sel && (bus.addr.cnt.idx == slot_idx(s));

      cnt_d[s] = cnt_q[s];
      if (cnt_incr[s] && !inhibit_eff[slot_idx(s)]) begin
        cnt_d[s] = cnt_mask[s] & (cnt_q[s] + 64'd1);  // wraps at counter width
      end
      // sw write overrides the increment on that half
      if (cnt_lo_we[s]) begin
        cnt_d[s][31:0] = cnt_mask[s][31:0] & bus.wdata;
      end else if (cnt_hi_we[s]) begin
        cnt_d[s][63:32] = cnt_mask[s][63:32] & bus.wdata;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcountinhibit_q <= '0;
      for (int unsigned s = 0; s < NumCnt; s++) begin
        cnt_q[s] <= '0;
      end
    end else begin
      mcountinhibit_q <= mcountinhibit_d;
      cnt_q           <= cnt_d;
    end
  end

endmodule

// File: csr_file_top.sv
`timescale 1ns/1ps

module csr_file_top import csr_pkg::*; #(
  parameter int unsigned HpmCounterNum   = 4,   // 1..4
  parameter int unsigned HpmCounterWidth = 40,  // 32..64
  parameter logic [31:0] MtvecResetAddr  = 32'h0000_0000
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // csr access from the core
  input  logic                csr_access_i,
  input  logic [11:0]         csr_addr_i,
  input  logic [31:0]         csr_wdata_i,
  input  csr_op_e             csr_op_i,
  input  logic                instr_new_i,
  // interrupt lines
  input  logic                irq_software_i,
  input  logic                irq_timer_i,
  input  logic                irq_external_i,
  // trap control
  input  logic                csr_save_cause_i,
  input  logic                csr_save_if_i,
  input  logic [31:0]         pc_if_i,
  input  logic [31:0]         pc_id_i,
  input  logic [MCAUSE_W-1:0] csr_mcause_i,
  input  logic [31:0]         csr_mtval_i,
  input  logic                csr_mret_i,
  // counter events
  input  logic                instr_ret_i,
  input  logic                mem_load_i,
  input  logic                mem_store_i,
  input  logic                branch_i,
  input  logic                branch_taken_i,
  output logic [31:0]         csr_rdata_o,
  output logic                illegal_csr_o,
  output logic                irq_pending_o,
  output logic                mstatus_mie_o,
  output logic [31:0]         mepc_o,
  output logic [31:0]         mtvec_o
);

  csr_bus_if trap_bus ();
  csr_bus_if cnt_bus ();

  csr_op_unit op_unit_i (
    .csr_access_i  (csr_access_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_op_i      (csr_op_i),
    .instr_new_i   (instr_new_i),
    .csr_rdata_o   (csr_rdata_o),
    .illegal_csr_o (illegal_csr_o),
    .trap_bus      (trap_bus.master),
    .cnt_bus       (cnt_bus.master)
  );

  csr_trap_regs #(
    .MtvecResetAddr (MtvecResetAddr)
  ) trap_regs_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .irq_software_i   (irq_software_i),
    .irq_timer_i      (irq_timer_i),
    .irq_external_i   (irq_external_i),
    .csr_save_cause_i (csr_save_cause_i),
    .csr_save_if_i    (csr_save_if_i),
    .pc_if_i          (pc_if_i),
    .pc_id_i          (pc_id_i),
    .csr_mcause_i     (csr_mcause_i),
    .csr_mtval_i      (csr_mtval_i),
    .csr_mret_i       (csr_mret_i),
    .bus              (trap_bus.slave),
    .irq_pending_o    (irq_pending_o),
    .mstatus_mie_o    (mstatus_mie_o),
    .mepc_o           (mepc_o),
    .mtvec_o          (mtvec_o)
  );

  csr_perf_counters #(
    .HpmCounterNum   (HpmCounterNum),
    .HpmCounterWidth (HpmCounterWidth)
  ) perf_counters_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_ret_i    (instr_ret_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .bus            (cnt_bus.slave)
  );

endmodule

// File: csr_checker.sv
`timescale 1ns/1ps

module csr_checker import csr_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                csr_access_i,
  input  logic [11:0]         csr_addr_i,
  input  logic [31:0]         csr_wdata_i,
  input  csr_op_e             csr_op_i,
  input  logic                instr_new_i,
  input  logic                irq_software_i,
  input  logic                irq_timer_i,
  input  logic                irq_external_i,
  input  logic                csr_save_cause_i,
  input  logic                csr_save_if_i,
  input  logic [31:0]         pc_if_i,
  input  logic [31:0]         pc_id_i,
  input  logic [MCAUSE_W-1:0] csr_mcause_i,
  input  logic [31:0]         csr_mtval_i,
  input  logic                csr_mret_i,
  input  logic                instr_ret_i,
  input  logic                mem_load_i,
  input  logic                mem_store_i,
  input  logic                branch_i,
  input  logic                branch_taken_i,
  input  logic [31:0]         csr_rdata_o,
  input  logic                illegal_csr_o,
  input  logic                irq_pending_o,
  input  logic                mstatus_mie_o,
  input  logic [31:0]         mepc_o,
  input  logic [31:0]         mtvec_o,
  input  int                  test_id_i,
  input  logic                test_end_i,
  output int                  err_cnt_o,
  output int                  chk_cnt_o
);

  localparam logic [63:0] HpmMask = 64'h0000_00FF_FFFF_FFFF;  // 40-bit counters
  localparam logic [31:0] Absent  = 32'hFFFF_FF80;            // idx 7 up read inhibited

  string       names [6] = '{"operations", "legalize", "illegal", "interrupts",
                             "trap_mret", "counters"};
  logic        m_mie, m_mpie;
  logic [31:0] m_ie, m_scratch, m_mepc, m_mcause, m_mtval, m_mtvec, m_inh;
  logic [63:0] m_cnt [7];  // by csr index, 1 unused
  logic [31:0] lines, w;
  logic [32:0] r;
  logic        ill_exp, we, old_mie, old_mpie;
  int          test_err;

  // {hit, data} for an address, from the model
  function automatic logic [32:0] ref_read(input logic [11:0] a);
    logic [4:0] idx;
    idx = a[4:0];
    case (a)
      12'h300: return {1'b1, 32'h1800 | (32'(m_mpie) << 7) | (32'(m_mie) << 3)};
      12'h301: return {1'b1, MISA_VALUE};
      12'h304: return {1'b1, m_ie};
      12'h305: return {1'b1, m_mtvec};
      12'h320: return {1'b1, m_inh | Absent};
      12'h340: return {1'b1, m_scratch};
      12'h341: return {1'b1, m_mepc};
      12'h342: return {1'b1, m_mcause};
      12'h343: return {1'b1, m_mtval};
      12'h344: return {1'b1, m_ie & lines};
      default: ;
    endcase
    if (a[11:5] == 7'h58 || a[11:5] == 7'h5C) begin
      if (idx == 1) return '0;
      if (idx > 6) return {1'b1, 32'h0};
      return {1'b1, a[7] ? m_cnt[idx][63:32] : m_cnt[idx][31:0]};
    end
    if (a[11:5] == 7'h19 && idx >= 3) return {1'b1, 32'h0};  // event selectors
    return '0;
  endfunction

  assign lines = {20'h0, irq_external_i, 3'b0, irq_timer_i, 3'b0, irq_software_i, 3'b0};

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {m_mie, m_mpie} = '0;
      {m_ie, m_scratch, m_mepc, m_mcause, m_mtval, m_inh} = '0;
      m_mtvec = 32'h0000_1001;
      for (int i = 0; i < 7; i++) m_cnt[i] = '0;
      err_cnt_o = 0;
      chk_cnt_o = 0;
      test_err  = 0;
    end else begin
      r       = ref_read(csr_addr_i);
      ill_exp = csr_access_i && (!r[32] || (csr_op_i != CSR_OP_READ &&
                                            csr_addr_i[11:10] == 2'b11));
      if (csr_access_i) begin
        chk_cnt_o++;
        if (csr_rdata_o !== r[31:0] || illegal_csr_o !== ill_exp) begin
          $display("ERR %s addr %h: expected %h/%b, actual %h/%b", names[test_id_i],
                   csr_addr_i, r[31:0], ill_exp, csr_rdata_o, illegal_csr_o);
          err_cnt_o++;
          test_err++;
        end
        if (irq_pending_o !== |(m_ie & lines) || mepc_o !== m_mepc) begin
          $display("ERR %s irq/mepc: expected %b/%h, actual %b/%h", names[test_id_i],
                   |(m_ie & lines), m_mepc, irq_pending_o, mepc_o);
          err_cnt_o++;
          test_err++;
        end
        if (mstatus_mie_o !== m_mie || mtvec_o !== m_mtvec) begin
          $display("ERR %s mie/mtvec: expected %b/%h, actual %b/%h", names[test_id_i],
                   m_mie, m_mtvec, mstatus_mie_o, mtvec_o);
          err_cnt_o++;
          test_err++;
        end
      end

      ////////////////////////////////////////////////////////////////////
      // model update
      ////////////////////////////////////////////////////////////////////
      case (csr_op_i)
        CSR_OP_SET:   w = csr_wdata_i | r[31:0];
        CSR_OP_CLEAR: w = r[31:0] & ~csr_wdata_i;
        default:      w = csr_wdata_i;
      endcase
      we       = csr_access_i && instr_new_i && csr_op_i != CSR_OP_READ && !ill_exp;
      old_mie  = m_mie;
      old_mpie = m_mpie;
      for (int i = 0; i < 7; i++) begin
        logic inc;
        inc = (i == 0) ? 1'b1 : (i == 2) ? instr_ret_i : (i == 3) ? mem_load_i :
              (i == 4) ? mem_store_i : (i == 5) ? branch_i : (i == 6) ? branch_taken_i : 1'b0;
        if (inc && !m_inh[i]) m_cnt[i] = (m_cnt[i] + 1) & ((i >= 3) ? HpmMask : '1);
      end
      if (we) begin
        case (csr_addr_i)
          12'h300: {m_mpie, m_mie} = {w[7], w[3]};
          12'h304: m_ie = w & 32'h888;
          12'h305: m_mtvec = {w[31:8], 8'h01};
          12'h320: m_inh = w & ~32'h2;
          12'h340: m_scratch = w;
          12'h341: m_mepc = w & ~32'h1;
          12'h342: m_mcause = w & 32'h8000_001F;
          12'h343: m_mtval = w;
          default: begin
            if (csr_addr_i[11:5] == 7'h58 && csr_addr_i[4:0] <= 6) begin
              m_cnt[csr_addr_i[4:0]][31:0] = w;
            end else if (csr_addr_i[11:5] == 7'h5C && csr_addr_i[4:0] <= 6) begin
              m_cnt[csr_addr_i[4:0]][63:32] =
                w & ((csr_addr_i[4:0] >= 3) ? HpmMask[63:32] : '1);
            end
          end
        endcase
      end
      if (csr_save_cause_i) begin  // wins over sw write
        m_mepc   = csr_save_if_i ? pc_if_i : pc_id_i;
        m_mcause = {csr_mcause_i[MCAUSE_W-1], 26'h0, csr_mcause_i[4:0]};
        m_mtval  = csr_mtval_i;
        m_mpie   = old_mie;
        m_mie    = 1'b0;
      end else if (csr_mret_i) begin
        m_mie  = old_mpie;
        m_mpie = 1'b1;
      end

      if (test_end_i) begin
        $display("test %-10s %s, %0d errors", names[test_id_i],
                 (test_err == 0) ? "ok" : "FAILED", test_err);
        test_err = 0;
      end
    end
  end

endmodule

// File: csr_asserts.sv
`timescale 1ns/1ps

module csr_asserts (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        csr_access_i,
  input logic        illegal_csr_o,
  input logic        csr_save_cause_i,
  input logic        mstatus_mie_o,
  input logic [31:0] mtvec_o
);

  int fail_cnt = 0;  // failed assertion count

  // illegal only ever flags an access
  illegal_needs_access: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !csr_access_i |-> !illegal_csr_o
  ) else begin
    $error("illegal_csr_o high with no csr access");
    fail_cnt++;
  end

  // handler starts with irqs off
  save_clears_mie: assert property (
    @(posedge clk_i) disable iff (!rst_ni) csr_save_cause_i |=> !mstatus_mie_o
  ) else begin
    $error("mstatus.mie still set after trap save");
    fail_cnt++;
  end

  mtvec_vectored: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mtvec_o[7:0] == 8'h01
  ) else begin
    $error("mtvec low byte is not 0x01");
    fail_cnt++;
  end

endmodule

bind csr_file_top csr_asserts asserts_i (.*);

// File: tb_csr_file.sv
`timescale 1ns/1ps

module tb_csr_file import csr_pkg::*; ();

  localparam int unsigned TimeoutCycles = 3000;  // all tests plus margin

  logic                clk_i;
  logic                rst_ni;
  logic                csr_access_i;
  logic [11:0]         csr_addr_i;
  logic [31:0]         csr_wdata_i;
  csr_op_e             csr_op_i;
  logic                instr_new_i;
  logic                irq_software_i, irq_timer_i, irq_external_i;
  logic                csr_save_cause_i, csr_save_if_i, csr_mret_i;
  logic [31:0]         pc_if_i, pc_id_i, csr_mtval_i;
  logic [MCAUSE_W-1:0] csr_mcause_i;
  logic                instr_ret_i, mem_load_i, mem_store_i, branch_i, branch_taken_i;
  logic [31:0]         csr_rdata_o, mepc_o, mtvec_o;
  logic                illegal_csr_o, irq_pending_o, mstatus_mie_o;
  int                  test_id_i;
  logic                test_end_i;
  int                  err_cnt_o, chk_cnt_o;
  int unsigned         pulses;

  csr_file_top #(
    .HpmCounterNum   (4),
    .HpmCounterWidth (40),
    .MtvecResetAddr  (32'h0000_1000)
  ) dut_i (.*);

  csr_checker checker_i (.*);  // same port names as the dut

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;  // 8 ns

  // one access, presented for a single cycle
  task automatic issue(input csr_op_e op, input logic [11:0] addr, input logic [31:0] wdata);
    csr_access_i = 1'b1;
    instr_new_i  = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = addr;
    csr_wdata_i  = wdata;
    @(negedge clk_i);
    csr_access_i = 1'b0;
    instr_new_i  = 1'b0;
    csr_op_i     = CSR_OP_READ;
  endtask

  task automatic end_test(input int id);
    test_id_i  = id;
    test_end_i = 1'b1;
    @(negedge clk_i);
    test_end_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hcd34_9db3));
    {csr_access_i, instr_new_i, csr_addr_i, csr_wdata_i} = '0;
    csr_op_i = CSR_OP_READ;
    {irq_software_i, irq_timer_i, irq_external_i} = '0;
    {csr_save_cause_i, csr_save_if_i, csr_mret_i} = '0;
    {pc_if_i, pc_id_i, csr_mtval_i, csr_mcause_i} = '0;
    {instr_ret_i, mem_load_i, mem_store_i, branch_i, branch_taken_i} = '0;
    test_id_i  = 0;
    test_end_i = 1'b0;
    rst_ni     = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // 0: operations on plain rw registers
    repeat (40) issue(csr_op_e'($urandom % 4), ($urandom % 2) ? CSR_MSCRATCH : CSR_MTVAL,
                      $urandom);
    issue(CSR_OP_READ, CSR_MSCRATCH, $urandom);
    issue(CSR_OP_READ, CSR_MTVAL, $urandom);
    end_test(0);

    // 1: legalized writes
    repeat (10) begin
      issue(CSR_OP_WRITE, CSR_MEPC, $urandom);
      issue(CSR_OP_WRITE, CSR_MCAUSE, $urandom);
      issue(CSR_OP_WRITE, CSR_MTVEC, $urandom);
      issue(CSR_OP_READ, CSR_MEPC, 0);
      issue(CSR_OP_READ, CSR_MCAUSE, 0);
      issue(CSR_OP_READ, CSR_MTVEC, 0);
      issue(CSR_OP_WRITE, CSR_MSTATUS, $urandom);
      issue(CSR_OP_READ, CSR_MSTATUS, 0);
    end
    issue(CSR_OP_READ, CSR_MISA, 0);
    end_test(1);

    // 2: illegal and absent addresses
    issue(CSR_OP_WRITE, CSR_MSCRATCH, 32'h5a5a_1234);
    issue(CSR_OP_WRITE, 12'h7C0, $urandom);  // unmapped
    issue(CSR_OP_READ, 12'hB01, 0);          // no mtime here
    issue(CSR_OP_WRITE, 12'h321, $urandom);  // selector idx 1
    issue(CSR_OP_READ, 12'h322, 0);
    issue(CSR_OP_WRITE, 12'hC00, $urandom);  // read-only space
    issue(CSR_OP_SET, 12'hF11, $urandom);
    issue(CSR_OP_READ, 12'hB07, 0);          // absent counter
    issue(CSR_OP_WRITE, 12'hB88, $urandom);
    issue(CSR_OP_WRITE, 12'h323, $urandom);  // selector reads zero
    issue(CSR_OP_READ, 12'h323, 0);
    issue(CSR_OP_READ, 12'h33F, 0);
    issue(CSR_OP_READ, CSR_MSCRATCH, 0);
    end_test(2);

    // 3: interrupt lines against mie
    repeat (16) begin
      {irq_software_i, irq_timer_i, irq_external_i} = 3'($urandom);
      issue(CSR_OP_WRITE, CSR_MIE, $urandom);
      issue(CSR_OP_READ, CSR_MIP, 0);
      issue(CSR_OP_READ, CSR_MIE, 0);
    end
    {irq_software_i, irq_timer_i, irq_external_i} = '0;
    end_test(3);

    // 4: trap save then mret, once per pc source
    for (int i = 0; i < 2; i++) begin
      issue(CSR_OP_SET, CSR_MSTATUS, 32'h8);  // mie on
      csr_save_cause_i = 1'b1;
      csr_save_if_i    = i[0];
      pc_if_i          = $urandom;
      pc_id_i          = $urandom;
      csr_mcause_i     = MCAUSE_W'($urandom);
      csr_mtval_i      = $urandom;
      @(negedge clk_i);
      csr_save_cause_i = 1'b0;
      issue(CSR_OP_READ, CSR_MEPC, 0);
      issue(CSR_OP_READ, CSR_MCAUSE, 0);
      issue(CSR_OP_READ, CSR_MTVAL, 0);
      issue(CSR_OP_READ, CSR_MSTATUS, 0);
      csr_mret_i = 1'b1;
      @(negedge clk_i);
      csr_mret_i = 1'b0;
      issue(CSR_OP_READ, CSR_MSTATUS, 0);
    end
    end_test(4);

    // 5: counters
    issue(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'hFFFF_FFFF);
    issue(CSR_OP_WRITE, CSR_MCYCLE, 32'h0000_1000);
    issue(CSR_OP_WRITE, CSR_MINSTRET, 32'h0000_2000);
    issue(CSR_OP_WRITE, 12'hB03, 32'h0000_0100);
    issue(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'hFFFF_FFF7);  // only counter 3
    pulses = $urandom % 20 + 5;
    repeat (pulses) begin
      mem_load_i  = 1'b1;
      mem_store_i = 1'($urandom);  // counter 4 stays inhibited
      instr_ret_i = 1'($urandom);
      @(negedge clk_i);
    end
    {mem_load_i, mem_store_i, instr_ret_i} = '0;
    issue(CSR_OP_READ, 12'hB03, 0);
    issue(CSR_OP_READ, 12'hB04, 0);
    issue(CSR_OP_WRITE, 12'hB83, 32'hFFFF_FFFF);
    issue(CSR_OP_READ, 12'hB83, 0);
    issue(CSR_OP_WRITE, 12'hB03, 32'hFFFF_FFFF);
    mem_load_i = 1'b1;  // wraps all 40 bits
    @(negedge clk_i);
    mem_load_i = 1'b0;
    issue(CSR_OP_READ, 12'hB03, 0);
    issue(CSR_OP_READ, 12'hB83, 0);
    issue(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'hFFFF_FFFF);
    issue(CSR_OP_READ, CSR_MCYCLE, 0);
    issue(CSR_OP_READ, CSR_MCYCLEH, 0);
    issue(CSR_OP_READ, CSR_MINSTRET, 0);
    issue(CSR_OP_READ, CSR_MCOUNTINHIBIT, 0);
    end_test(5);

    @(negedge clk_i);
    $display("checks %0d, errors %0d, assertion failures %0d", chk_cnt_o, err_cnt_o,
             dut_i.asserts_i.fail_cnt);
    if (err_cnt_o == 0 && chk_cnt_o > 0 && dut_i.asserts_i.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TimeoutCycles * 8);
    $display("timeout: tests did not finish within %0d cycles", TimeoutCycles);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: src.f
csr_pkg.sv
csr_bus_if.sv
csr_op_unit.sv
csr_trap_regs.sv
csr_perf_counters.sv
csr_file_top.sv
csr_checker.sv
csr_asserts.sv
tb_csr_file.sv

// File: Bender.yml
package:
  name: csr_file

sources:
  - csr_pkg.sv
  - csr_bus_if.sv
  - csr_op_unit.sv
  - csr_trap_regs.sv
  - csr_perf_counters.sv
  - csr_file_top.sv
  - target: test
    files:
      - csr_checker.sv
      - csr_asserts.sv
      - tb_csr_file.sv
